//--- design/chimney_pkg.sv
// Widths and channel codes of the AXI-to-NoC chimney
// Request and response payload unions with their two views each
// Request and response flit layouts

package chimney_pkg;

  // AXI field widths
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned DataWidth  = 32;
  localparam int unsigned StrbWidth  = 4;
  localparam int unsigned IdWidth    = 4;
  localparam int unsigned LenWidth   = 8;
  localparam int unsigned RespWidth  = 2;

  // NoC header widths
  localparam int unsigned CoordWidth = 4;
  localparam int unsigned ChWidth    = 3;

  // Pad bits that fill the smaller view of each union
  localparam int unsigned ReqPadWidth = IdWidth + AddrWidth + LenWidth - DataWidth - StrbWidth - 1;
  localparam int unsigned RspPadWidth = DataWidth + 1;

  // Channel codes carried in the flit header
  localparam logic [ChWidth-1:0] ChAw = 3'd0;
  localparam logic [ChWidth-1:0] ChW  = 3'd1;
  localparam logic [ChWidth-1:0] ChAr = 3'd2;
  localparam logic [ChWidth-1:0] ChB  = 3'd3;
  localparam logic [ChWidth-1:0] ChR  = 3'd4;

  ////////////////////////////////////////
  // Request payload

  // Address view, shared by AW and AR
  typedef struct packed {
    logic [IdWidth-1:0]     id;
    logic [AddrWidth-1:0]   addr;
    logic [LenWidth-1:0]    len;
  } req_ax_t;

  typedef struct packed {
    logic [DataWidth-1:0]   data;
    logic [StrbWidth-1:0]   strb;
    logic                   last;
    logic [ReqPadWidth-1:0] pad;
  } req_w_t;

  typedef union packed {
    req_ax_t ax;
    req_w_t  w;
  } req_payload_u;

  ////////////////////////////////////////
  // Response payload

  typedef struct packed {
    logic [IdWidth-1:0]     id;
    logic [DataWidth-1:0]   data;
    logic [RespWidth-1:0]   resp;
    logic                   last;
  } rsp_r_t;

  typedef struct packed {
    logic [IdWidth-1:0]     id;
    logic [RespWidth-1:0]   resp;
    logic [RspPadWidth-1:0] pad;
  } rsp_b_t;

  typedef union packed {
    rsp_r_t r;
    rsp_b_t b;
  } rsp_payload_u;

  ////////////////////////////////////////
  // Flits

  typedef struct packed {
    logic [CoordWidth-1:0] dst_x;
    logic [CoordWidth-1:0] dst_y;
    logic [CoordWidth-1:0] src_x;
    logic [CoordWidth-1:0] src_y;
    logic [ChWidth-1:0]    ch;
    logic                  last;
    req_payload_u          payload;
  } req_flit_t;

  typedef struct packed {
    logic [CoordWidth-1:0] dst_x;
    logic [CoordWidth-1:0] dst_y;
    logic [CoordWidth-1:0] src_x;
    logic [CoordWidth-1:0] src_y;
    logic [ChWidth-1:0]    ch;
    logic                  last;
    rsp_payload_u          payload;
  } rsp_flit_t;

endpackage

//--- design/ax_chan_if.sv
// AXI address channel bundle, one instance each for AW and AR
// Modports for the lane controller and for the datapath

`timescale 1ns/1ps

interface ax_chan_if;
  import chimney_pkg::*;

  logic                 valid;
  logic                 ready;
  logic [IdWidth-1:0]   id;
  logic [AddrWidth-1:0] addr;
  logic [LenWidth-1:0]  len;

  // Handshake side, owned by the arbiter
  modport ctrl (
    input  valid,
    output ready
  );

  // Payload side, read by routing and packing
  modport data (
    input  id,
    input  addr,
    input  len
  );

endinterface

//--- design/chimney_ctrl.sv
// Request link controller of the chimney
// AW/W sequencer, wormhole lock and round-robin lane arbitration

`timescale 1ns/1ps

module chimney_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_i,
  ax_chan_if.ctrl                         aw_if,
  ax_chan_if.ctrl                         ar_if,
  input  logic                            w_valid_i,
  input  logic                            w_last_i,
  input  logic                            req_ready_i,
  output logic                            w_ready_o,
  output logic                            req_valid_o,
  output logic                            aw_fire_o,
  output logic [chimney_pkg::ChWidth-1:0] sel_ch_o
);
  import chimney_pkg::*;

  // Sequencer, low in the AW state and high while W beats pass
  logic in_w_q;
  // Set while a write packet is partly on the link
  logic lock_q;
  // Round-robin pointer, high when the read lane has priority
  logic rd_prio_q;

  logic wr_req;
  logic rd_req;
  logic sel_wr;
  logic flit_last;
  logic req_fire;

  ////////////////////////////////////////
  // Lane requests and grant

  // Write lane offers AW or W depending on the sequencer
  assign wr_req = in_w_q ? w_valid_i : aw_if.valid;
  assign rd_req = ar_if.valid;

  always_comb begin
    if (lock_q) begin
      // Only the write lane can hold the link
      sel_wr = 1'b1;
    end else begin
      sel_wr = wr_req && (!rd_req || !rd_prio_q);
    end
  end

  assign req_valid_o = sel_wr ? wr_req : rd_req;
  assign req_fire    = req_valid_o && req_ready_i;

  assign sel_ch_o = !sel_wr ? ChAr : (in_w_q ? ChW : ChAw);

  // AW opens a packet, AR is a single flit
  assign flit_last = sel_wr ? (in_w_q && w_last_i) : 1'b1;

  assign aw_if.ready = req_fire && sel_wr && !in_w_q;
  assign w_ready_o   = req_fire && sel_wr && in_w_q;
  assign ar_if.ready = req_fire && !sel_wr;

  assign aw_fire_o = aw_if.valid && aw_if.ready;

  ////////////////////////////////////////
  // State registers

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      in_w_q    <= 1'b0;
      lock_q    <= 1'b0;
      rd_prio_q <= 1'b0;
    end else begin
      if (aw_fire_o) begin
        in_w_q <= 1'b1;
      end else if (w_valid_i && w_ready_o && w_last_i) begin
        in_w_q <= 1'b0;
      end
      if (req_fire) begin
        lock_q    <= !flit_last;
        // Give priority to the lane that did not just send
        rd_prio_q <= sel_wr;
      end
    end
  end

endmodule

//--- design/dest_lookup.sv
// Destination lookup for request flits
// XY fields taken from the address, AW destination held for W beats

`timescale 1ns/1ps

module dest_lookup #(
  parameter int unsigned AddrOffsetX = 12,
  parameter int unsigned AddrOffsetY = 16
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  ax_chan_if.data                            aw_if,
  ax_chan_if.data                            ar_if,
  input  logic                               aw_fire_i,
  output logic [chimney_pkg::CoordWidth-1:0] aw_dst_x_o,
  output logic [chimney_pkg::CoordWidth-1:0] aw_dst_y_o,
  output logic [chimney_pkg::CoordWidth-1:0] ar_dst_x_o,
  output logic [chimney_pkg::CoordWidth-1:0] ar_dst_y_o,
  output logic [chimney_pkg::CoordWidth-1:0] w_dst_x_o,
  output logic [chimney_pkg::CoordWidth-1:0] w_dst_y_o
);
  import chimney_pkg::*;

  logic [CoordWidth-1:0] w_dst_x_q;
  logic [CoordWidth-1:0] w_dst_y_q;

  // Node coordinates sit in fixed address bit fields
  assign aw_dst_x_o = aw_if.addr[AddrOffsetX +: CoordWidth];
  assign aw_dst_y_o = aw_if.addr[AddrOffsetY +: CoordWidth];
  assign ar_dst_x_o = ar_if.addr[AddrOffsetX +: CoordWidth];
  assign ar_dst_y_o = ar_if.addr[AddrOffsetY +: CoordWidth];

  // W beats follow their AW to the same node
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      w_dst_x_q <= '0;
      w_dst_y_q <= '0;
    end else if (aw_fire_i) begin
      w_dst_x_q <= aw_dst_x_o;
      w_dst_y_q <= aw_dst_y_o;
    end
  end

  assign w_dst_x_o = w_dst_x_q;
  assign w_dst_y_o = w_dst_y_q;

endmodule

//--- design/req_packer.sv
// Request flit packing for AW, W and AR
// Output mux driven by the channel chosen by the arbiter

`timescale 1ns/1ps

module req_packer (
  ax_chan_if.data                            aw_if,
  ax_chan_if.data                            ar_if,
  input  logic [chimney_pkg::DataWidth-1:0]  w_data_i,
  input  logic [chimney_pkg::StrbWidth-1:0]  w_strb_i,
  input  logic                               w_last_i,
  input  logic [chimney_pkg::CoordWidth-1:0] node_x_i,
  input  logic [chimney_pkg::CoordWidth-1:0] node_y_i,
  input  logic [chimney_pkg::CoordWidth-1:0] aw_dst_x_i,
  input  logic [chimney_pkg::CoordWidth-1:0] aw_dst_y_i,
  input  logic [chimney_pkg::CoordWidth-1:0] ar_dst_x_i,
  input  logic [chimney_pkg::CoordWidth-1:0] ar_dst_y_i,
  input  logic [chimney_pkg::CoordWidth-1:0] w_dst_x_i,
  input  logic [chimney_pkg::CoordWidth-1:0] w_dst_y_i,
  input  logic [chimney_pkg::ChWidth-1:0]    sel_ch_i,
  output chimney_pkg::req_flit_t             req_flit_o
);
  import chimney_pkg::*;

  req_flit_t aw_flit;
  req_flit_t w_flit;
  req_flit_t ar_flit;

  always_comb begin
    aw_flit                = '0;
    aw_flit.dst_x          = aw_dst_x_i;
    aw_flit.dst_y          = aw_dst_y_i;
    aw_flit.src_x          = node_x_i;
    aw_flit.src_y          = node_y_i;
    aw_flit.ch             = ChAw;
    // More flits of this packet follow
    aw_flit.last           = 1'b0;
    aw_flit.payload.ax.id   = aw_if.id;
    aw_flit.payload.ax.addr = aw_if.addr;
    aw_flit.payload.ax.len  = aw_if.len;
  end

  always_comb begin
    w_flit                 = '0;
    w_flit.dst_x           = w_dst_x_i;
    w_flit.dst_y           = w_dst_y_i;
    w_flit.src_x           = node_x_i;
    w_flit.src_y           = node_y_i;
    w_flit.ch              = ChW;
    w_flit.last            = w_last_i;
    w_flit.payload.w.data  = w_data_i;
    w_flit.payload.w.strb  = w_strb_i;
    w_flit.payload.w.last  = w_last_i;
  end

  always_comb begin
    ar_flit                 = '0;
    ar_flit.dst_x           = ar_dst_x_i;
    ar_flit.dst_y           = ar_dst_y_i;
    ar_flit.src_x           = node_x_i;
    ar_flit.src_y           = node_y_i;
    ar_flit.ch              = ChAr;
    ar_flit.last            = 1'b1;
    ar_flit.payload.ax.id   = ar_if.id;
    ar_flit.payload.ax.addr = ar_if.addr;
    ar_flit.payload.ax.len  = ar_if.len;
  end

  always_comb begin
    case (sel_ch_i)
      ChAw:    req_flit_o = aw_flit;
      ChW:     req_flit_o = w_flit;
      ChAr:    req_flit_o = ar_flit;
      default: req_flit_o = '0;
    endcase
  end

endmodule

//--- design/rsp_unpacker.sv
// Response side of the chimney
// Two-entry spill buffer from the NoC and the B/R channel split

`timescale 1ns/1ps

module rsp_unpacker (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  chimney_pkg::rsp_flit_t             rsp_flit_i,
  input  logic                               rsp_valid_i,
  input  logic                               b_ready_i,
  input  logic                               r_ready_i,
  output logic                               rsp_ready_o,
  output logic                               b_valid_o,
  output logic [chimney_pkg::IdWidth-1:0]    b_id_o,
  output logic [chimney_pkg::RespWidth-1:0]  b_resp_o,
  output logic                               r_valid_o,
  output logic [chimney_pkg::IdWidth-1:0]    r_id_o,
  output logic [chimney_pkg::DataWidth-1:0]  r_data_o,
  output logic [chimney_pkg::RespWidth-1:0]  r_resp_o,
  output logic                               r_last_o
);
  import chimney_pkg::*;

  rsp_flit_t  buf_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;

  rsp_flit_t  head;
  logic       head_valid;
  logic       push;
  logic       pop;

  ////////////////////////////////////////
  // Spill buffer

  assign rsp_ready_o = (count_q != 2'd2);
  assign push        = rsp_valid_i && rsp_ready_o;

  assign head       = buf_q[rd_ptr_q];
  assign head_valid = (count_q != 2'd0);

  // Flits with a non-response code are dropped so they cannot block the queue
  assign pop = (b_valid_o && b_ready_i) || (r_valid_o && r_ready_i) ||
               (head_valid && (head.ch != ChB) && (head.ch != ChR));

  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[wr_ptr_q] <= rsp_flit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  ////////////////////////////////////////
  // Channel split

  assign b_valid_o = head_valid && (head.ch == ChB);
  assign b_id_o    = head.payload.b.id;
  assign b_resp_o  = head.payload.b.resp;

  assign r_valid_o = head_valid && (head.ch == ChR);
  assign r_id_o    = head.payload.r.id;
  assign r_data_o  = head.payload.r.data;
  assign r_resp_o  = head.payload.r.resp;
  assign r_last_o  = head.payload.r.last;

endmodule

//--- design/axi_noc_chimney.sv
// Manager-side AXI-to-NoC chimney, top level
// Plain AXI and NoC ports, address channel bundles and the submodules

`timescale 1ns/1ps

module axi_noc_chimney #(
  parameter int unsigned AddrOffsetX = 12,
  parameter int unsigned AddrOffsetY = 16
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  // Position of this node in the mesh
  input  logic [chimney_pkg::CoordWidth-1:0] node_x_i,
  input  logic [chimney_pkg::CoordWidth-1:0] node_y_i,
  // AXI write address
  input  logic                               aw_valid_i,
  output logic                               aw_ready_o,
  input  logic [chimney_pkg::IdWidth-1:0]    aw_id_i,
  input  logic [chimney_pkg::AddrWidth-1:0]  aw_addr_i,
  input  logic [chimney_pkg::LenWidth-1:0]   aw_len_i,
  // AXI write data
  input  logic                               w_valid_i,
  output logic                               w_ready_o,
  input  logic [chimney_pkg::DataWidth-1:0]  w_data_i,
  input  logic [chimney_pkg::StrbWidth-1:0]  w_strb_i,
  input  logic                               w_last_i,
  // AXI read address
  input  logic                               ar_valid_i,
  output logic                               ar_ready_o,
  input  logic [chimney_pkg::IdWidth-1:0]    ar_id_i,
  input  logic [chimney_pkg::AddrWidth-1:0]  ar_addr_i,
  input  logic [chimney_pkg::LenWidth-1:0]   ar_len_i,
  // AXI write response
  output logic                               b_valid_o,
  input  logic                               b_ready_i,
  output logic [chimney_pkg::IdWidth-1:0]    b_id_o,
  output logic [chimney_pkg::RespWidth-1:0]  b_resp_o,
  // AXI read data
  output logic                               r_valid_o,
  input  logic                               r_ready_i,
  output logic [chimney_pkg::IdWidth-1:0]    r_id_o,
  output logic [chimney_pkg::DataWidth-1:0]  r_data_o,
  output logic [chimney_pkg::RespWidth-1:0]  r_resp_o,
  output logic                               r_last_o,
  // NoC request link
  output chimney_pkg::req_flit_t             req_flit_o,
  output logic                               req_valid_o,
  input  logic                               req_ready_i,
  // NoC response link
  input  chimney_pkg::rsp_flit_t             rsp_flit_i,
  input  logic                               rsp_valid_i,
  output logic                               rsp_ready_o
);
  import chimney_pkg::*;

  logic                  aw_fire;
  logic [ChWidth-1:0]    sel_ch;
  logic [CoordWidth-1:0] aw_dst_x;
  logic [CoordWidth-1:0] aw_dst_y;
  logic [CoordWidth-1:0] ar_dst_x;
  logic [CoordWidth-1:0] ar_dst_y;
  logic [CoordWidth-1:0] w_dst_x;
  logic [CoordWidth-1:0] w_dst_y;

  ////////////////////////////////////////
  // Address channel bundles

  ax_chan_if aw_if ();
  ax_chan_if ar_if ();

  assign aw_if.valid = aw_valid_i;
  assign aw_if.id    = aw_id_i;
  assign aw_if.addr  = aw_addr_i;
  assign aw_if.len   = aw_len_i;
  assign aw_ready_o  = aw_if.ready;

  assign ar_if.valid = ar_valid_i;
  assign ar_if.id    = ar_id_i;
  assign ar_if.addr  = ar_addr_i;
  assign ar_if.len   = ar_len_i;
  assign ar_ready_o  = ar_if.ready;

  ////////////////////////////////////////
  // Request path

  chimney_ctrl i_ctrl (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .aw_if       ( aw_if       ),
    .ar_if       ( ar_if       ),
    .w_valid_i   ( w_valid_i   ),
    .w_last_i    ( w_last_i    ),
    .req_ready_i ( req_ready_i ),
    .w_ready_o   ( w_ready_o   ),
    .req_valid_o ( req_valid_o ),
    .aw_fire_o   ( aw_fire     ),
    .sel_ch_o    ( sel_ch      )
  );

  dest_lookup #(
    .AddrOffsetX ( AddrOffsetX ),
    .AddrOffsetY ( AddrOffsetY )
  ) i_dest_lookup (
    .clk_i      ( clk_i    ),
    .rst_i      ( rst_i    ),
    .aw_if      ( aw_if    ),
    .ar_if      ( ar_if    ),
    .aw_fire_i  ( aw_fire  ),
    .aw_dst_x_o ( aw_dst_x ),
    .aw_dst_y_o ( aw_dst_y ),
    .ar_dst_x_o ( ar_dst_x ),
    .ar_dst_y_o ( ar_dst_y ),
    .w_dst_x_o  ( w_dst_x  ),
    .w_dst_y_o  ( w_dst_y  )
  );

  req_packer i_req_packer (
    .aw_if      ( aw_if      ),
    .ar_if      ( ar_if      ),
    .w_data_i   ( w_data_i   ),
    .w_strb_i   ( w_strb_i   ),
    .w_last_i   ( w_last_i   ),
    .node_x_i   ( node_x_i   ),
    .node_y_i   ( node_y_i   ),
    .aw_dst_x_i ( aw_dst_x   ),
    .aw_dst_y_i ( aw_dst_y   ),
    .ar_dst_x_i ( ar_dst_x   ),
    .ar_dst_y_i ( ar_dst_y   ),
    .w_dst_x_i  ( w_dst_x    ),
    .w_dst_y_i  ( w_dst_y    ),
    .sel_ch_i   ( sel_ch     ),
    .req_flit_o ( req_flit_o )
  );

  ////////////////////////////////////////
  // Response path

  rsp_unpacker i_rsp_unpacker (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .rsp_flit_i  ( rsp_flit_i  ),
    .rsp_valid_i ( rsp_valid_i ),
    .b_ready_i   ( b_ready_i   ),
    .r_ready_i   ( r_ready_i   ),
    .rsp_ready_o ( rsp_ready_o ),
    .b_valid_o   ( b_valid_o   ),
    .b_id_o      ( b_id_o      ),
    .b_resp_o    ( b_resp_o    ),
    .r_valid_o   ( r_valid_o   ),
    .r_id_o      ( r_id_o      ),
    .r_data_o    ( r_data_o    ),
    .r_resp_o    ( r_resp_o    ),
    .r_last_o    ( r_last_o    )
  );

endmodule

//--- tb/chimney_props.sv
// Concurrent checks on the chimney top level
// Quiet outputs in reset, stable request flits, spill buffer fill

`timescale 1ns/1ps

module chimney_props (
  input logic                   clk_i,
  input logic                   rst_i,
  input logic                   req_valid_o,
  input logic                   req_ready_i,
  input chimney_pkg::req_flit_t req_flit_o,
  input logic                   w_ready_o,
  input logic                   b_valid_o,
  input logic                   b_ready_i,
  input logic                   r_valid_o,
  input logic                   r_ready_i,
  input logic                   rsp_valid_i,
  input logic                   rsp_ready_o
);

  // Flits held in the response buffer, counted at its ports
  logic [1:0] held_q;
  logic       rsp_push;
  logic       rsp_pop;

  assign rsp_push = rsp_valid_i && rsp_ready_o;
  assign rsp_pop  = (b_valid_o && b_ready_i) || (r_valid_o && r_ready_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      held_q <= 2'd0;
    end else begin
      held_q <= held_q + {1'b0, rsp_push} - {1'b0, rsp_pop};
    end
  end

  // First edge skipped, the buffer state is unknown before it
  a_quiet_in_reset: assert property (@(posedge clk_i)
    rst_i && $past(rst_i) |-> !req_valid_o && !w_ready_o && !b_valid_o && !r_valid_o)
    else $error("Valid output high during reset");

  a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    req_valid_o && !req_ready_i |=> $stable(req_flit_o))
    else $error("Request flit changed under back-pressure");

  a_rsp_full: assert property (@(posedge clk_i) disable iff (rst_i)
    held_q == 2'd2 |-> !rsp_ready_o)
    else $error("Response buffer ready while two flits are held");

endmodule

bind axi_noc_chimney chimney_props i_props (.*);

//--- tb/chimney_tb.sv
// Testbench for the AXI-to-NoC chimney
// Directed read, write, wormhole, response and back-pressure tests

`timescale 1ns/1ps

module chimney_tb;
  import chimney_pkg::*;

  localparam int unsigned OffX = 12;
  localparam int unsigned OffY = 16;
  localparam int Timeout = 100;

  logic                  clk_i = 1'b0;
  logic                  rst_i;
  logic [CoordWidth-1:0] node_x_i;
  logic [CoordWidth-1:0] node_y_i;
  logic                  aw_valid_i;
  logic                  aw_ready_o;
  logic [IdWidth-1:0]    aw_id_i;
  logic [AddrWidth-1:0]  aw_addr_i;
  logic [LenWidth-1:0]   aw_len_i;
  logic                  w_valid_i;
  logic                  w_ready_o;
  logic [DataWidth-1:0]  w_data_i;
  logic [StrbWidth-1:0]  w_strb_i;
  logic                  w_last_i;
  logic                  ar_valid_i;
  logic                  ar_ready_o;
  logic [IdWidth-1:0]    ar_id_i;
  logic [AddrWidth-1:0]  ar_addr_i;
  logic [LenWidth-1:0]   ar_len_i;
  logic                  b_valid_o;
  logic                  b_ready_i;
  logic [IdWidth-1:0]    b_id_o;
  logic [RespWidth-1:0]  b_resp_o;
  logic                  r_valid_o;
  logic                  r_ready_i;
  logic [IdWidth-1:0]    r_id_o;
  logic [DataWidth-1:0]  r_data_o;
  logic [RespWidth-1:0]  r_resp_o;
  logic                  r_last_o;
  req_flit_t             req_flit_o;
  logic                  req_valid_o;
  logic                  req_ready_i;
  rsp_flit_t             rsp_flit_i;
  logic                  rsp_valid_i;
  logic                  rsp_ready_o;

  integer    seed = 32'hbea5846a;
  int        err_cnt = 0;
  int        accepted = 0;
  // Response flits accepted by the DUT, oldest first
  rsp_flit_t rsp_q [$];

  always #50 clk_i = ~clk_i;

  axi_noc_chimney #(
    .AddrOffsetX ( OffX ),
    .AddrOffsetY ( OffY )
  ) UUT (.*);

  ////////////////////////////////////////
  // Reporting and compare tasks

  task automatic abort_run();
    err_cnt++;
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_req_flit(input req_flit_t got, input req_flit_t exp);
    report_mismatch("req_flit_o", got, exp);
  endtask

  task automatic check_b(input rsp_b_t got, input rsp_b_t exp);
    report_mismatch("b_id_o", 64'(got.id), 64'(exp.id));
    report_mismatch("b_resp_o", 64'(got.resp), 64'(exp.resp));
  endtask

  task automatic check_r(input rsp_r_t got, input rsp_r_t exp);
    report_mismatch("r_id_o", 64'(got.id), 64'(exp.id));
    report_mismatch("r_data_o", 64'(got.data), 64'(exp.data));
    report_mismatch("r_resp_o", 64'(got.resp), 64'(exp.resp));
    report_mismatch("r_last_o", 64'(got.last), 64'(exp.last));
  endtask

  ////////////////////////////////////////
  // Expected flits

  // AW and AR flits, destination from the address fields
  function automatic req_flit_t addr_flit(input logic [ChWidth-1:0] ch,
      input logic [IdWidth-1:0] id, input logic [AddrWidth-1:0] addr,
      input logic [LenWidth-1:0] len);
    req_flit_t f;
    f = '0;
    f.dst_x = addr[OffX +: CoordWidth];
    f.dst_y = addr[OffY +: CoordWidth];
    f.src_x = node_x_i;
    f.src_y = node_y_i;
    f.ch = ch;
    f.last = (ch == ChAr);
    f.payload.ax.id = id;
    f.payload.ax.addr = addr;
    f.payload.ax.len = len;
    return f;
  endfunction

  function automatic req_flit_t data_flit(input logic [CoordWidth-1:0] dx,
      input logic [CoordWidth-1:0] dy, input logic [DataWidth-1:0] data,
      input logic [StrbWidth-1:0] strb, input logic last);
    req_flit_t f;
    f = '0;
    f.dst_x = dx;
    f.dst_y = dy;
    f.src_x = node_x_i;
    f.src_y = node_y_i;
    f.ch = ChW;
    f.last = last;
    f.payload.w.data = data;
    f.payload.w.strb = strb;
    f.payload.w.last = last;
    return f;
  endfunction

  function automatic rsp_flit_t random_rsp_flit();
    rsp_flit_t   f;
    logic [31:0] rnd;
    rnd = $random(seed);
    f = '0;
    f.dst_x = node_x_i;
    f.dst_y = node_y_i;
    f.src_x = rnd[23:20];
    f.src_y = rnd[27:24];
    f.last = 1'b1;
    if (rnd[0]) begin
      f.ch = ChR;
      f.payload.r.id = rnd[7:4];
      f.payload.r.data = $random(seed);
      f.payload.r.resp = rnd[9:8];
      f.payload.r.last = rnd[10];
    end else begin
      f.ch = ChB;
      f.payload.b.id = rnd[7:4];
      f.payload.b.resp = rnd[9:8];
    end
    return f;
  endfunction

  ////////////////////////////////////////
  // Link handshakes

  task automatic wait_req_flit(output req_flit_t flit);
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!(req_valid_o && req_ready_i) && n < Timeout);
    if (!(req_valid_o && req_ready_i)) begin
      $display("Timeout: no request flit sent within %0d cycles", Timeout);
      abort_run();
    end
    flit = req_flit_o;
  endtask

  task automatic send_rsp_flits(input int n);
    int t;
    for (int i = 0; i < n; i++) begin
      @(negedge clk_i);
      rsp_flit_i = random_rsp_flit();
      rsp_valid_i = 1'b1;
      t = 0;
      do begin
        @(posedge clk_i);
        t++;
      end while (!rsp_ready_o && t < Timeout);
      if (!rsp_ready_o) begin
        $display("Timeout: response flit %0d was never accepted", i);
        abort_run();
      end
      rsp_q.push_back(rsp_flit_i);
      accepted++;
    end
    @(negedge clk_i);
    rsp_valid_i = 1'b0;
  endtask

  task automatic collect_responses(input int n);
    rsp_flit_t exp;
    rsp_b_t    got_b;
    rsp_r_t    got_r;
    int        t;
    for (int i = 0; i < n; i++) begin
      t = 0;
      do begin
        @(posedge clk_i);
        t++;
      end while (!(b_valid_o && b_ready_i) && !(r_valid_o && r_ready_i) && t < Timeout);
      if (!(b_valid_o && b_ready_i) && !(r_valid_o && r_ready_i)) begin
        $display("Timeout: response %0d never came out on B or R", i);
        abort_run();
      end
      if (rsp_q.size() == 0) begin
        $display("A response came out at %0d ns that was never sent", $time);
        abort_run();
      end
      exp = rsp_q.pop_front();
      if (exp.ch == ChB) begin
        if (!b_valid_o) begin
          $display("Expected a B response at %0d ns, got an R response", $time);
          abort_run();
        end
        got_b = '0;
        got_b.id = b_id_o;
        got_b.resp = b_resp_o;
        check_b(got_b, exp.payload.b);
      end else begin
        if (!r_valid_o) begin
          $display("Expected an R response at %0d ns, got a B response", $time);
          abort_run();
        end
        got_r.id = r_id_o;
        got_r.data = r_data_o;
        got_r.resp = r_resp_o;
        got_r.last = r_last_o;
        check_r(got_r, exp.payload.r);
      end
    end
  endtask

  ////////////////////////////////////////
  // Directed tests

  // Optional stall cycles hold the request link back first
  task automatic read_request_test(input int stall);
    logic [31:0] addr;
    logic [31:0] rnd;
    req_flit_t   got;
    req_flit_t   exp;
    addr = $random(seed);
    rnd = $random(seed);
    exp = addr_flit(ChAr, rnd[3:0], addr, rnd[15:8]);
    @(negedge clk_i);
    req_ready_i = (stall == 0);
    ar_valid_i = 1'b1;
    ar_id_i = rnd[3:0];
    ar_addr_i = addr;
    ar_len_i = rnd[15:8];
    for (int i = 0; i < stall; i++) begin
      @(posedge clk_i);
      report_mismatch("req_valid_o", 64'(req_valid_o), 64'd1);
      report_mismatch("ar_ready_o", 64'(ar_ready_o), 64'd0);
      check_req_flit(req_flit_o, exp);
    end
    if (stall > 0) begin
      @(negedge clk_i);
      req_ready_i = 1'b1;
    end
    wait_req_flit(got);
    report_mismatch("ar_ready_o", 64'(ar_ready_o), 64'd1);
    check_req_flit(got, exp);
    @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  task automatic write_burst_test(input int beats, input int early_w, input bit raise_ar);
    logic [31:0]           addr;
    logic [31:0]           ar_addr;
    logic [31:0]           rnd;
    logic [CoordWidth-1:0] dx;
    logic [CoordWidth-1:0] dy;
    req_flit_t             got;
    req_flit_t             exp_ar;
    addr = $random(seed);
    rnd = $random(seed);
    dx = addr[OffX +: CoordWidth];
    dy = addr[OffY +: CoordWidth];
    exp_ar = '0;
    @(negedge clk_i);
    w_valid_i = 1'b1;
    w_data_i = $random(seed);
    w_strb_i = rnd[3:0];
    w_last_i = (beats == 1);
    // W without its AW must wait
    for (int i = 0; i < early_w; i++) begin
      @(posedge clk_i);
      if (w_ready_o || req_valid_o) begin
        $display("W beat was taken before its AW at %0d ns", $time);
        abort_run();
      end
    end
    if (early_w > 0) begin
      @(negedge clk_i);
    end
    aw_valid_i = 1'b1;
    aw_id_i = rnd[7:4];
    aw_addr_i = addr;
    aw_len_i = 8'(beats - 1);
    wait_req_flit(got);
    report_mismatch("aw_ready_o", 64'(aw_ready_o), 64'd1);
    check_req_flit(got, addr_flit(ChAw, rnd[7:4], addr, 8'(beats - 1)));
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    if (raise_ar) begin
      ar_addr = $random(seed);
      ar_valid_i = 1'b1;
      ar_id_i = rnd[11:8];
      ar_addr_i = ar_addr;
      ar_len_i = 8'd0;
      exp_ar = addr_flit(ChAr, rnd[11:8], ar_addr, 8'd0);
    end
    for (int i = 0; i < beats; i++) begin
      wait_req_flit(got);
      report_mismatch("w_ready_o", 64'(w_ready_o), 64'd1);
      check_req_flit(got, data_flit(dx, dy, w_data_i, w_strb_i, i == beats - 1));
      @(negedge clk_i);
      if (i < beats - 1) begin
        rnd = $random(seed);
        w_data_i = $random(seed);
        w_strb_i = rnd[3:0];
        w_last_i = (i + 1 == beats - 1);
      end else begin
        w_valid_i = 1'b0;
        w_last_i = 1'b0;
      end
    end
    // The read only gets the link once the packet is complete
    if (raise_ar) begin
      wait_req_flit(got);
      check_req_flit(got, exp_ar);
      @(negedge clk_i);
      ar_valid_i = 1'b0;
    end
  endtask

  task automatic response_test();
    @(negedge clk_i);
    b_ready_i = 1'b1;
    r_ready_i = 1'b1;
    fork
      send_rsp_flits(8);
      collect_responses(8);
    join
  endtask

  task automatic rsp_backpressure_test();
    @(negedge clk_i);
    b_ready_i = 1'b0;
    r_ready_i = 1'b0;
    accepted = 0;
    fork
      send_rsp_flits(5);
      begin
        repeat (10) @(posedge clk_i);
        if (accepted > 2) begin
          $display("Response buffer took %0d flits with both readies low", accepted);
          abort_run();
        end
        @(negedge clk_i);
        b_ready_i = 1'b1;
        r_ready_i = 1'b1;
        collect_responses(5);
      end
    join
  endtask

  ////////////////////////////////////////
  // Main sequence

  initial begin
    rst_i = 1'b1;
    node_x_i = 4'd3;
    node_y_i = 4'd5;
    aw_valid_i = 1'b0;
    aw_id_i = '0;
    aw_addr_i = '0;
    aw_len_i = '0;
    w_valid_i = 1'b0;
    w_data_i = '0;
    w_strb_i = '0;
    w_last_i = 1'b0;
    ar_valid_i = 1'b0;
    ar_id_i = '0;
    ar_addr_i = '0;
    ar_len_i = '0;
    b_ready_i = 1'b1;
    r_ready_i = 1'b1;
    req_ready_i = 1'b1;
    rsp_flit_i = '0;
    rsp_valid_i = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    read_request_test(0);
    write_burst_test(4, 20, 1'b0);
    write_burst_test(3, 0, 1'b1);
    response_test();
    read_request_test(6);
    rsp_backpressure_test();

    repeat (2) @(posedge clk_i);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

//--- flist.f
design/chimney_pkg.sv
design/ax_chan_if.sv
design/chimney_ctrl.sv
design/dest_lookup.sv
design/req_packer.sv
design/rsp_unpacker.sv
design/axi_noc_chimney.sv
tb/chimney_props.sv
tb/chimney_tb.sv

//--- Makefile
# Verilator build and run of the chimney testbench

SRCS := $(wildcard design/*.sv tb/*.sv)

obj_dir/Vchimney_tb: $(SRCS) flist.f
	verilator --binary --timing --assert --top-module chimney_tb -f flist.f -Mdir obj_dir

.PHONY: all run clean

all: obj_dir/Vchimney_tb

# The run passes only if the log holds the pass line
run: obj_dir/Vchimney_tb
	./obj_dir/Vchimney_tb > sim.log 2>&1; cat sim.log
	grep -qx "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
